/* project.f */
xcel_pkg.sv
sort_pkg.sv
elem_buf_if.sv
array_mem.sv
sort_ctrl.sv
mem_xfer.sv
merge_sorter.sv
sort_xcel_top.sv
tb_mem.sv
sort_assert.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= sort_xcel_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all lint lint_rtl build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only -Wall --timescale $(TIMESCALE) xcel_pkg.sv sort_pkg.sv \
		elem_buf_if.sv array_mem.sv sort_ctrl.sv mem_xfer.sv merge_sorter.sv \
		sort_xcel_top.sv --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_top.sv */
// Directed testbench for the merge-sort accelerator with a stalling memory model
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;
  import xcel_pkg::*;

  // 7 passes of about 256 cycles for 128 elements, 256 transfers of up to ~10
  // stalled cycles, plus memory setup; generous margin on top
  localparam int TIMEOUT_CYCLES = 200000;

  logic        clk;
  logic        reset;
  logic        xcel_req_val;
  logic        xcel_req_rdy;
  logic        xcel_req_write;
  reg_idx_t    xcel_req_addr;
  word_t       xcel_req_data;
  logic        xcel_resp_val;
  logic        xcel_resp_rdy;
  word_t       xcel_resp_data;
  logic        mem_req_val;
  logic        mem_req_rdy;
  logic        mem_req_write;
  addr_t       mem_req_addr;
  word_t       mem_req_data;
  logic        mem_resp_val;
  logic        mem_resp_rdy;
  word_t       mem_resp_data;
  logic        poke_en;
  logic [8:0]  poke_addr;
  logic [31:0] poke_data;

  int          seed;
  int          cycles;
  int          mismatches;
  int          failures;
  word_t       ref_vals [128];

  sort_xcel_top dut_i (.*);

  tb_mem mem_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ---------------------------------------------------------------------
  // Checking and reporting
  // ---------------------------------------------------------------------

  task automatic final_report();
    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      failures++;
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      final_report();
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      mismatches++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Plain insertion sort, ascending unsigned
  task automatic sort_reference(input int count);
    int    i;
    int    j;
    word_t key;
    for (i = 1; i < count; i++) begin
      key = ref_vals[i];
      j   = i - 1;
      while (j >= 0 && ref_vals[j] > key) begin
        ref_vals[j+1] = ref_vals[j];
        j--;
      end
      ref_vals[j+1] = key;
    end
  endtask

  // ---------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------

  // One accelerator request, waits for the handshake
  task automatic xcel_access(input logic wr, input reg_idx_t addr, input word_t data,
                             input logic jitter, output word_t resp);
    logic fired;
    fired = 1'b0;
    resp  = '0;
    xcel_req_val   <= 1'b1;
    xcel_req_write <= wr;
    xcel_req_addr  <= addr;
    xcel_req_data  <= data;
    xcel_resp_rdy  <= jitter ? 1'($random(seed)) : 1'b1;
    while (!fired) begin
      @(posedge clk);
      if (xcel_req_val && xcel_req_rdy) begin
        fired = 1'b1;
        resp  = xcel_resp_data;
        assert (xcel_resp_val && xcel_resp_rdy) else begin
          failures++;
          $display("Accelerator request accepted with no response in the same cycle");
        end
      end else if (jitter) begin
        xcel_resp_rdy <= 1'($random(seed));
      end
    end
    xcel_req_val  <= 1'b0;
    xcel_resp_rdy <= 1'b1;
  endtask

  // Pattern over the whole memory, then random words into one array
  task automatic fill_memory();
    int i;
    for (i = 0; i < 512; i++) begin
      poke_en   <= 1'b1;
      poke_addr <= 9'(i);
      poke_data <= 32'hC0DE_0000 + 32'(i);
      @(posedge clk);
    end
    poke_en <= 1'b0;
  endtask

  task automatic load_array(input int base, input int count, input word_t mask);
    int i;
    for (i = 0; i < count; i++) begin
      poke_en   <= 1'b1;
      poke_addr <= 9'(base + i);
      poke_data <= $random(seed) & mask;
      @(posedge clk);
    end
    poke_en <= 1'b0;
    // Last poke lands in memory on this edge
    @(posedge clk);
  endtask

  // Full job: configure, go, wait on xr0, then compare memory
  task automatic run_sort(input string name, input int base, input int count,
                          input logic jitter);
    int    i;
    word_t resp;
    word_t guard_lo;
    word_t guard_hi;
    guard_lo = mem_i.mem[base-1];
    guard_hi = mem_i.mem[base+count];
    for (i = 0; i < count; i++) begin
      ref_vals[i] = mem_i.mem[base+i];
    end
    sort_reference(count);
    xcel_access(1'b1, XR_BASE, word_t'(base * 4), jitter, resp);
    check_word({name, " xr1 write"}, 32'd0, resp);
    xcel_access(1'b1, XR_SIZE, word_t'(count), jitter, resp);
    check_word({name, " xr2 write"}, 32'd0, resp);
    xcel_access(1'b1, XR_GO, 32'd0, jitter, resp);
    check_word({name, " go write"}, 32'd0, resp);
    // Stalls here until the job ends
    xcel_access(1'b0, XR_GO, 32'd0, jitter, resp);
    check_word({name, " done read"}, 32'd1, resp);
    for (i = 0; i < count; i++) begin
      check_word($sformatf("%s elem %0d", name, i), ref_vals[i], mem_i.mem[base+i]);
    end
    check_word({name, " guard below"}, guard_lo, mem_i.mem[base-1]);
    check_word({name, " guard above"}, guard_hi, mem_i.mem[base+count]);
  endtask

  // ---------------------------------------------------------------------
  // Directed tests
  // ---------------------------------------------------------------------

  task automatic test_registers();
    word_t resp;
    xcel_access(1'b1, XR_BASE, 32'h0000_0100, 1'b0, resp);
    check_word("registers xr1 write", 32'd0, resp);
    xcel_access(1'b1, XR_SIZE, 32'd5, 1'b0, resp);
    check_word("registers xr2 write", 32'd0, resp);
    xcel_access(1'b0, XR_GO, 32'd0, 1'b0, resp);
    check_word("registers idle xr0 read", 32'd1, resp);
  endtask

  task automatic test_small();
    load_array(16, 8, 32'hFFFF_FFFF);
    run_sort("small", 16, 8, 1'b0);
  endtask

  task automatic test_duplicates();
    // Values 0..7 over 13 slots force repeats
    load_array(40, 13, 32'h0000_0007);
    run_sort("duplicates", 40, 13, 1'b0);
  endtask

  task automatic test_large();
    load_array(200, 128, 32'hFFFF_FFFF);
    run_sort("large", 200, 128, 1'b1);
  endtask

  task automatic test_trivial();
    load_array(110, 1, 32'hFFFF_FFFF);
    run_sort("count zero", 100, 0, 1'b0);
    run_sort("count one", 110, 1, 1'b0);
  endtask

  task automatic test_back_to_back();
    load_array(340, 20, 32'hFFFF_FFFF);
    load_array(380, 37, 32'h0000_00FF);
    run_sort("first of pair", 340, 20, 1'b0);
    run_sort("second of pair", 380, 37, 1'b0);
  endtask

  initial begin
    seed           = 33489;
    cycles         = 0;
    mismatches     = 0;
    failures       = 0;
    reset          <= 1'b1;
    xcel_req_val   <= 1'b0;
    xcel_req_write <= 1'b0;
    xcel_req_addr  <= '0;
    xcel_req_data  <= '0;
    xcel_resp_rdy  <= 1'b1;
    poke_en        <= 1'b0;
    poke_addr      <= '0;
    poke_data      <= '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    fill_memory();
    test_registers();
    test_small();
    test_duplicates();
    test_large();
    test_trivial();
    test_back_to_back();
    final_report();
  end

endmodule

/* sort_assert.sv */
// Protocol checks on the accelerator and memory handshakes of the sort accelerator
module sort_assert (
  input logic        clk,
  input logic        reset,
  input logic        mem_req_val,
  input logic        mem_req_rdy,
  input logic        mem_req_write,
  input logic [31:0] mem_req_addr,
  input logic [31:0] mem_req_data,
  input logic        mem_resp_val,
  input logic        mem_resp_rdy,
  input logic        xcel_req_val,
  input logic        xcel_resp_val
);
  timeunit 1ns;
  timeprecision 1ps;

  logic awaiting;

  // Set by an accepted request, cleared by an accepted response
  always_ff @(posedge clk) begin
    if (reset) begin
      awaiting <= 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      awaiting <= 1'b1;
    end else if (mem_resp_val && mem_resp_rdy) begin
      awaiting <= 1'b0;
    end
  end

  // Stalled memory request holds its fields
  req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_write)
      && $stable(mem_req_addr) && $stable(mem_req_data))
    else $error("memory request changed while stalled");

  // Only one request in flight
  one_outstanding: assert property (@(posedge clk) disable iff (reset)
    !(mem_req_val && awaiting))
    else $error("memory request issued while a response is awaited");

  resp_needs_req: assert property (@(posedge clk) disable iff (reset)
    xcel_resp_val |-> xcel_req_val)
    else $error("accelerator response without a request");

endmodule

bind sort_xcel_top sort_assert assert_i (
  .clk           (clk),
  .reset         (reset),
  .mem_req_val   (mem_req_val),
  .mem_req_rdy   (mem_req_rdy),
  .mem_req_write (mem_req_write),
  .mem_req_addr  (mem_req_addr),
  .mem_req_data  (mem_req_data),
  .mem_resp_val  (mem_resp_val),
  .mem_resp_rdy  (mem_resp_rdy),
  .xcel_req_val  (xcel_req_val),
  .xcel_resp_val (xcel_resp_val)
);

/* tb_mem.sv */
// Testbench memory model, word addressed, with random request and response stalls
module tb_mem (
  input  logic        clk,
  input  logic        reset,
  input  logic        mem_req_val,
  output logic        mem_req_rdy,
  input  logic        mem_req_write,
  input  logic [31:0] mem_req_addr,
  input  logic [31:0] mem_req_data,
  output logic        mem_resp_val,
  input  logic        mem_resp_rdy,
  output logic [31:0] mem_resp_data,
  input  logic        poke_en,
  input  logic [8:0]  poke_addr,
  input  logic [31:0] poke_data
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] mem [512];
  int          seed;
  logic        pending;
  logic        req_ok;
  logic        resp_ok;

  initial seed = 33489;

  // Single response slot, a new request waits until it drains
  assign mem_req_rdy  = !pending && req_ok;
  assign mem_resp_val = pending && resp_ok;

  always @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      req_ok  <= 1'b0;
      resp_ok <= 1'b0;
    end else begin
      // Roughly one stall cycle in four on each side
      req_ok  <= ($random(seed) & 3) != 0;
      resp_ok <= ($random(seed) & 3) != 0;
      if (mem_req_val && mem_req_rdy) begin
        pending <= 1'b1;
        if (mem_req_write) begin
          mem[mem_req_addr[10:2]] <= mem_req_data;
          mem_resp_data           <= '0;
        end else begin
          mem_resp_data <= mem[mem_req_addr[10:2]];
        end
      end
      if (mem_resp_val && mem_resp_rdy) begin
        pending <= 1'b0;
      end
    end
    // Backdoor load from the testbench, only used while the DUT is idle
    if (poke_en) begin
      mem[poke_addr] <= poke_data;
    end
  end

endmodule

/* sort_xcel_top.sv */
// Merge-sort accelerator top with plain accelerator and memory handshake ports
module sort_xcel_top (
  input  logic               clk,
  input  logic               reset,

  input  logic               xcel_req_val,
  output logic               xcel_req_rdy,
  input  logic               xcel_req_write,
  input  xcel_pkg::reg_idx_t xcel_req_addr,
  input  xcel_pkg::word_t    xcel_req_data,

  output logic               xcel_resp_val,
  input  logic               xcel_resp_rdy,
  output xcel_pkg::word_t    xcel_resp_data,

  output logic               mem_req_val,
  input  logic               mem_req_rdy,
  output logic               mem_req_write,
  output xcel_pkg::addr_t    mem_req_addr,
  output xcel_pkg::word_t    mem_req_data,

  input  logic               mem_resp_val,
  output logic               mem_resp_rdy,
  input  xcel_pkg::word_t    mem_resp_data
);
  import xcel_pkg::*;
  import sort_pkg::*;

  addr_t     base_addr;
  elem_cnt_t elem_count;
  logic      xfer_start;
  logic      xfer_write;
  logic      xfer_done;
  logic      sort_start;
  logic      sort_done;
  logic      sort_owns;

  // One buffer port per client
  elem_buf_if xfer_buf ();
  elem_buf_if sort_buf ();

  sort_ctrl ctrl_i (
    .clk            (clk),
    .reset          (reset),
    .xcel_req_val   (xcel_req_val),
    .xcel_req_rdy   (xcel_req_rdy),
    .xcel_req_write (xcel_req_write),
    .xcel_req_addr  (xcel_req_addr),
    .xcel_req_data  (xcel_req_data),
    .xcel_resp_val  (xcel_resp_val),
    .xcel_resp_rdy  (xcel_resp_rdy),
    .xcel_resp_data (xcel_resp_data),
    .base_addr      (base_addr),
    .elem_count     (elem_count),
    .xfer_start     (xfer_start),
    .xfer_write     (xfer_write),
    .sort_start     (sort_start),
    .sort_owns      (sort_owns),
    .xfer_done      (xfer_done),
    .sort_done      (sort_done)
  );

  mem_xfer xfer_i (
    .clk           (clk),
    .reset         (reset),
    .xfer_start    (xfer_start),
    .xfer_write    (xfer_write),
    .base_addr     (base_addr),
    .elem_count    (elem_count),
    .xfer_done     (xfer_done),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_resp_data (mem_resp_data),
    .buf_port      (xfer_buf.client)
  );

  merge_sorter sorter_i (
    .clk        (clk),
    .reset      (reset),
    .sort_start (sort_start),
    .elem_count (elem_count),
    .sort_done  (sort_done),
    .buf_port   (sort_buf.client)
  );

  array_mem buf_i (
    .clk       (clk),
    .xfer_buf  (xfer_buf.store),
    .sort_buf  (sort_buf.store),
    .sort_owns (sort_owns)
  );

endmodule

/* merge_sorter.sv */
// Bottom-up merge engine with a private scratch array and per-pass copy-back
module merge_sorter (
  input  logic                clk,
  input  logic                reset,
  input  logic                sort_start,
  input  sort_pkg::elem_cnt_t elem_count,
  output logic                sort_done,
  elem_buf_if.client          buf_port
);
  import xcel_pkg::*;
  import sort_pkg::*;

  merge_state_t state;

  word_t     scratch [MAX_ELEMS];
  elem_cnt_t width;
  elem_cnt_t start;
  elem_cnt_t left;
  elem_cnt_t left_end;
  elem_cnt_t right;
  elem_cnt_t right_end;
  elem_cnt_t out_idx;
  elem_cnt_t copy_idx;

  elem_cnt_t run_mid;
  elem_cnt_t run_end;
  elem_cnt_t width_next;
  word_t     head_a;
  word_t     head_b;
  logic      left_ok;
  logic      right_ok;
  logic      take_left;

  // ---------------------------------------------------------------------
  // Run bounds and head compare
  // ---------------------------------------------------------------------

  // Width stays at or below 64 in a pass, so sums fit the count type
  assign run_mid    = start + width;
  assign run_end    = run_mid + width;
  assign width_next = width << 1;

  // Heads of both runs read in the same cycle
  assign buf_port.rd_a_idx = left[$bits(elem_idx_t)-1:0];
  assign buf_port.rd_b_idx = right[$bits(elem_idx_t)-1:0];
  assign head_a = buf_port.rd_a_data;
  assign head_b = buf_port.rd_b_data;

  assign left_ok   = (left < left_end);
  assign right_ok  = (right < right_end);
  // Ties go left, keeps the sort stable
  assign take_left = left_ok && (!right_ok || head_a <= head_b);

  // Scratch fill during merge
  always_ff @(posedge clk) begin
    if (state == MS_MERGE && (left_ok || right_ok)) begin
      scratch[out_idx[$bits(elem_idx_t)-1:0]] <= take_left ? head_a : head_b;
    end
  end

  // Copy-back into the buffer
  assign buf_port.wr_en   = (state == MS_COPY);
  assign buf_port.wr_idx  = copy_idx[$bits(elem_idx_t)-1:0];
  assign buf_port.wr_data = scratch[copy_idx[$bits(elem_idx_t)-1:0]];

  // ---------------------------------------------------------------------
  // State machine
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= MS_IDLE;
      sort_done <= 1'b0;
      width     <= '0;
      start     <= '0;
      left      <= '0;
      left_end  <= '0;
      right     <= '0;
      right_end <= '0;
      out_idx   <= '0;
      copy_idx  <= '0;
    end else begin
      sort_done <= 1'b0;
      case (state)
        MS_IDLE: begin
          if (sort_start) begin
            width <= elem_cnt_t'(1);
            start <= '0;
            // Zero or one element is already sorted
            state <= (elem_count > elem_cnt_t'(1)) ? MS_RUN_INIT : MS_PASS_DONE;
          end
        end
        MS_RUN_INIT: begin
          // Clamp both runs to the array end
          left      <= start;
          left_end  <= (run_mid < elem_count) ? run_mid : elem_count;
          right     <= (run_mid < elem_count) ? run_mid : elem_count;
          right_end <= (run_end < elem_count) ? run_end : elem_count;
          out_idx   <= start;
          state     <= MS_MERGE;
        end
        MS_MERGE: begin
          if (left_ok || right_ok) begin
            out_idx <= out_idx + 1'b1;
            if (take_left) begin
              left <= left + 1'b1;
            end else begin
              right <= right + 1'b1;
            end
          end else begin
            state <= MS_NEXT_RUN;
          end
        end
        MS_NEXT_RUN: begin
          // Next pair starts where this one ended
          if (right_end < elem_count) begin
            start <= right_end;
            state <= MS_RUN_INIT;
          end else begin
            copy_idx <= '0;
            state    <= MS_COPY;
          end
        end
        MS_COPY: begin
          copy_idx <= copy_idx + 1'b1;
          if (copy_idx + 1'b1 == elem_count) begin
            state <= MS_PASS_DONE;
          end
        end
        MS_PASS_DONE: begin
          if (width_next >= elem_count) begin
            sort_done <= 1'b1;
            state     <= MS_IDLE;
          end else begin
            width <= width_next;
            start <= '0;
            state <= MS_RUN_INIT;
          end
        end
        default: state <= MS_IDLE;
      endcase
    end
  end

endmodule

/* mem_xfer.sv */
// Load/store sequencer moving the array between memory and the element buffer
module mem_xfer (
  input  logic                clk,
  input  logic                reset,
  input  logic                xfer_start,
  input  logic                xfer_write,
  input  xcel_pkg::addr_t     base_addr,
  input  sort_pkg::elem_cnt_t elem_count,
  output logic                xfer_done,
  output logic                mem_req_val,
  input  logic                mem_req_rdy,
  output logic                mem_req_write,
  output xcel_pkg::addr_t     mem_req_addr,
  output xcel_pkg::word_t     mem_req_data,
  input  logic                mem_resp_val,
  output logic                mem_resp_rdy,
  input  xcel_pkg::word_t     mem_resp_data,
  elem_buf_if.client          buf_port
);
  import xcel_pkg::*;
  import sort_pkg::*;

  logic      active;
  logic      resp_wait;
  logic      write_mode;
  elem_cnt_t idx;
  elem_idx_t buf_idx;
  logic      last;

  assign last    = (idx == elem_count);
  assign buf_idx = idx[$bits(elem_idx_t)-1:0];

  // One request in flight at most
  assign mem_req_val   = active && !resp_wait && !last;
  assign mem_req_write = write_mode;
  assign mem_req_addr  = base_addr + addr_t'(idx) * WORD_BYTES;
  assign mem_req_data  = buf_port.rd_a_data;
  assign mem_resp_rdy  = active && resp_wait;

  // Store data comes from read port a
  assign buf_port.rd_a_idx = buf_idx;
  assign buf_port.rd_b_idx = buf_idx;

  // Load data lands straight in the buffer, write acks are dropped
  assign buf_port.wr_en   = mem_resp_rdy && mem_resp_val && !write_mode;
  assign buf_port.wr_idx  = buf_idx;
  assign buf_port.wr_data = mem_resp_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      active     <= 1'b0;
      resp_wait  <= 1'b0;
      write_mode <= 1'b0;
      idx        <= '0;
      xfer_done  <= 1'b0;
    end else begin
      xfer_done <= 1'b0;
      if (xfer_start) begin
        active     <= 1'b1;
        resp_wait  <= 1'b0;
        write_mode <= xfer_write;
        idx        <= '0;
      end else if (active) begin
        if (resp_wait) begin
          // Response closes this element
          if (mem_resp_val) begin
            resp_wait <= 1'b0;
            idx       <= idx + 1'b1;
          end
        end else if (last) begin
          active    <= 1'b0;
          xfer_done <= 1'b1;
        end else if (mem_req_rdy) begin
          resp_wait <= 1'b1;
        end
      end
    end
  end

endmodule

/* sort_ctrl.sv */
// Accelerator register file and phase controller that runs load, sort and store
module sort_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                xcel_req_val,
  output logic                xcel_req_rdy,
  input  logic                xcel_req_write,
  input  xcel_pkg::reg_idx_t  xcel_req_addr,
  input  xcel_pkg::word_t     xcel_req_data,
  output logic                xcel_resp_val,
  input  logic                xcel_resp_rdy,
  output xcel_pkg::word_t     xcel_resp_data,
  output xcel_pkg::addr_t     base_addr,
  output sort_pkg::elem_cnt_t elem_count,
  output logic                xfer_start,
  output logic                xfer_write,
  output logic                sort_start,
  output logic                sort_owns,
  input  logic                xfer_done,
  input  logic                sort_done
);
  import xcel_pkg::*;
  import sort_pkg::*;

  phase_t phase;
  logic   idle;
  logic   req_fire;
  logic   go_write;

  // ---------------------------------------------------------------------
  // Accelerator request/response
  // ---------------------------------------------------------------------

  assign idle = (phase == PH_IDLE);

  // Pass-through handshake while idle, both stall otherwise
  assign xcel_req_rdy  = idle && xcel_resp_rdy;
  assign xcel_resp_val = idle && xcel_req_val;

  // Reads report done, writes acknowledge with zero
  assign xcel_resp_data = xcel_req_write ? '0 : word_t'(1);

  assign req_fire = xcel_req_val && xcel_req_rdy;
  assign go_write = req_fire && xcel_req_write && (xcel_req_addr == XR_GO);

  // Config registers, only written while idle
  always_ff @(posedge clk) begin
    if (req_fire && xcel_req_write) begin
      if (xcel_req_addr == XR_BASE) begin
        base_addr <= addr_t'(xcel_req_data);
      end
      if (xcel_req_addr == XR_SIZE) begin
        // Low bits only, counts above MAX_ELEMS unsupported
        elem_count <= xcel_req_data[$bits(elem_cnt_t)-1:0];
      end
    end
  end

  // ---------------------------------------------------------------------
  // Phase sequencing
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      phase      <= PH_IDLE;
      xfer_start <= 1'b0;
      xfer_write <= 1'b0;
      sort_start <= 1'b0;
    end else begin
      // Start strobes last one cycle
      xfer_start <= 1'b0;
      sort_start <= 1'b0;
      case (phase)
        PH_IDLE: begin
          if (go_write) begin
            phase      <= PH_LOAD;
            xfer_start <= 1'b1;
            xfer_write <= 1'b0;
          end
        end
        PH_LOAD: begin
          if (xfer_done) begin
            phase      <= PH_SORT;
            sort_start <= 1'b1;
          end
        end
        PH_SORT: begin
          // Write back in place once merging ends
          if (sort_done) begin
            phase      <= PH_STORE;
            xfer_start <= 1'b1;
            xfer_write <= 1'b1;
          end
        end
        PH_STORE: begin
          if (xfer_done) begin
            phase <= PH_IDLE;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // Buffer handed to the merge engine for the whole sort phase
  assign sort_owns = (phase == PH_SORT);

endmodule

/* array_mem.sv */
// Shared element buffer, muxed between the transfer unit and the merge engine
module array_mem (
  input logic       clk,
  elem_buf_if.store xfer_buf,
  elem_buf_if.store sort_buf,
  input logic       sort_owns
);
  import xcel_pkg::*;
  import sort_pkg::*;

  word_t     mem [MAX_ELEMS];
  logic      wr_en;
  elem_idx_t wr_idx;
  word_t     wr_data;
  elem_idx_t rd_a_idx;
  elem_idx_t rd_b_idx;
  word_t     rd_a_data;
  word_t     rd_b_data;

  // Merge engine owns the buffer only during the sort phase
  assign wr_en    = sort_owns ? sort_buf.wr_en    : xfer_buf.wr_en;
  assign wr_idx   = sort_owns ? sort_buf.wr_idx   : xfer_buf.wr_idx;
  assign wr_data  = sort_owns ? sort_buf.wr_data  : xfer_buf.wr_data;
  assign rd_a_idx = sort_owns ? sort_buf.rd_a_idx : xfer_buf.rd_a_idx;
  assign rd_b_idx = sort_owns ? sort_buf.rd_b_idx : xfer_buf.rd_b_idx;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // Asynchronous reads, same data to both clients
  assign rd_a_data = mem[rd_a_idx];
  assign rd_b_data = mem[rd_b_idx];

  assign xfer_buf.rd_a_data = rd_a_data;
  assign xfer_buf.rd_b_data = rd_b_data;
  assign sort_buf.rd_a_data = rd_a_data;
  assign sort_buf.rd_b_data = rd_b_data;

endmodule

/* elem_buf_if.sv */
// Element buffer access bundle for one client with a write port and two read ports
interface elem_buf_if;
  import xcel_pkg::*;
  import sort_pkg::*;

  // Write port, driven by the client
  logic      wr_en;
  elem_idx_t wr_idx;
  word_t     wr_data;

  // Read indices, driven by the client
  elem_idx_t rd_a_idx;
  elem_idx_t rd_b_idx;

  // Combinational read data from the buffer
  word_t     rd_a_data;
  word_t     rd_b_data;

  modport client (
    output wr_en, wr_idx, wr_data, rd_a_idx, rd_b_idx,
    input  rd_a_data, rd_b_data
  );

  modport store (
    input  wr_en, wr_idx, wr_data, rd_a_idx, rd_b_idx,
    output rd_a_data, rd_b_data
  );

endinterface

/* sort_pkg.sv */
// Element buffer sizes and state encodings for the sort engine and phase controller
package sort_pkg;

  // Buffer depth, also the largest legal count
  localparam int MAX_ELEMS = 128;

  // Index into the element buffer or scratch array
  typedef logic [$clog2(MAX_ELEMS)-1:0] elem_idx_t;

  // Count or run bound, one bit wider so that MAX_ELEMS fits
  typedef logic [$clog2(MAX_ELEMS):0] elem_cnt_t;

  // Top-level job phases
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_LOAD,
    PH_SORT,
    PH_STORE
  } phase_t;

  // Merge engine states
  typedef enum logic [2:0] {
    MS_IDLE,
    MS_RUN_INIT,
    MS_MERGE,
    MS_NEXT_RUN,
    MS_COPY,
    MS_PASS_DONE
  } merge_state_t;

endpackage

/* xcel_pkg.sv */
// Accelerator register map and memory message field types for the sort accelerator
package xcel_pkg;

  // ---------------------------------------------------------------------
  // Message field types
  // ---------------------------------------------------------------------

  // Data word carried on both request and response streams
  typedef logic [31:0] word_t;

  // Byte address on the memory request stream
  typedef logic [31:0] addr_t;

  // Accelerator register index
  typedef logic [4:0] reg_idx_t;

  // ---------------------------------------------------------------------
  // Register map
  // ---------------------------------------------------------------------

  // Go on write, done on read
  localparam reg_idx_t XR_GO   = 5'd0;
  // Array base address
  localparam reg_idx_t XR_BASE = 5'd1;
  // Element count
  localparam reg_idx_t XR_SIZE = 5'd2;

  // Address step between neighbouring elements
  localparam addr_t WORD_BYTES = 32'd4;

endpackage
